// ==== common/desCtrlPkg.sv ====
package desCtrlPkg;

   localparam int BlockW = 64;
   localparam int HalfW = 32; // one Feistel half
   localparam int KeyW = 64; // includes parity bits
   localparam int SubkeyW = 48;
   localparam int NumRounds = 16;
   localparam int RoundIdxW = 4;

   localparam int CdW = 56; // key bits after PC-1
   localparam int HalfCdW = 28; // width of C and of D

   // controller states
   typedef enum logic [2:0]
   {
      Idle, // waiting for req
      Load, // IP and PC-1 on the next edge
      Round, // sixteen Feistel rounds
      Finish, // final permutation into result
      Done // ack handshake
   } ctrlState;

endpackage

// ==== common/desTablesPkg.sv ====
package desTablesPkg;

   // standard DES tables, 1-based bit numbers counted from the msb
   localparam int ipTable [64] = '{
      58, 50, 42, 34, 26, 18, 10, 2, 60, 52, 44, 36, 28, 20, 12, 4,
      62, 54, 46, 38, 30, 22, 14, 6, 64, 56, 48, 40, 32, 24, 16, 8,
      57, 49, 41, 33, 25, 17, 9, 1, 59, 51, 43, 35, 27, 19, 11, 3,
      61, 53, 45, 37, 29, 21, 13, 5, 63, 55, 47, 39, 31, 23, 15, 7};

   localparam int fpTable [64] = '{ // inverse of ipTable
      40, 8, 48, 16, 56, 24, 64, 32, 39, 7, 47, 15, 55, 23, 63, 31,
      38, 6, 46, 14, 54, 22, 62, 30, 37, 5, 45, 13, 53, 21, 61, 29,
      36, 4, 44, 12, 52, 20, 60, 28, 35, 3, 43, 11, 51, 19, 59, 27,
      34, 2, 42, 10, 50, 18, 58, 26, 33, 1, 41, 9, 49, 17, 57, 25};

   localparam int eTable [48] = '{ // 32 -> 48 expansion
      32, 1, 2, 3, 4, 5, 4, 5, 6, 7, 8, 9,
      8, 9, 10, 11, 12, 13, 12, 13, 14, 15, 16, 17,
      16, 17, 18, 19, 20, 21, 20, 21, 22, 23, 24, 25,
      24, 25, 26, 27, 28, 29, 28, 29, 30, 31, 32, 1};

   localparam int pTable [32] = '{
      16, 7, 20, 21, 29, 12, 28, 17, 1, 15, 23, 26, 5, 18, 31, 10,
      2, 8, 24, 14, 32, 27, 3, 9, 19, 13, 30, 6, 22, 11, 4, 25};

   localparam int pc1Table [56] = '{ // parity bits dropped
      57, 49, 41, 33, 25, 17, 9, 1, 58, 50, 42, 34, 26, 18,
      10, 2, 59, 51, 43, 35, 27, 19, 11, 3, 60, 52, 44, 36,
      63, 55, 47, 39, 31, 23, 15, 7, 62, 54, 46, 38, 30, 22,
      14, 6, 61, 53, 45, 37, 29, 21, 13, 5, 28, 20, 12, 4};

   localparam int pc2Table [48] = '{
      14, 17, 11, 24, 1, 5, 3, 28, 15, 6, 21, 10,
      23, 19, 12, 4, 26, 8, 16, 7, 27, 20, 13, 2,
      41, 52, 31, 37, 47, 55, 30, 40, 51, 45, 33, 48,
      44, 49, 39, 56, 34, 53, 46, 42, 50, 36, 29, 32};

   localparam int shiftTable [16] = '{1, 1, 2, 2, 2, 2, 2, 2, 1, 2, 2, 2, 2, 2, 2, 1};

   // S1..S8, each entry indexed by {row, column}
   localparam logic [3:0] sboxTable [8][64] = '{
      '{14, 4, 13, 1, 2, 15, 11, 8, 3, 10, 6, 12, 5, 9, 0, 7,
        0, 15, 7, 4, 14, 2, 13, 1, 10, 6, 12, 11, 9, 5, 3, 8,
        4, 1, 14, 8, 13, 6, 2, 11, 15, 12, 9, 7, 3, 10, 5, 0,
        15, 12, 8, 2, 4, 9, 1, 7, 5, 11, 3, 14, 10, 0, 6, 13},
      '{15, 1, 8, 14, 6, 11, 3, 4, 9, 7, 2, 13, 12, 0, 5, 10,
        3, 13, 4, 7, 15, 2, 8, 14, 12, 0, 1, 10, 6, 9, 11, 5,
        0, 14, 7, 11, 10, 4, 13, 1, 5, 8, 12, 6, 9, 3, 2, 15,
        13, 8, 10, 1, 3, 15, 4, 2, 11, 6, 7, 12, 0, 5, 14, 9},
      '{10, 0, 9, 14, 6, 3, 15, 5, 1, 13, 12, 7, 11, 4, 2, 8,
        13, 7, 0, 9, 3, 4, 6, 10, 2, 8, 5, 14, 12, 11, 15, 1,
        13, 6, 4, 9, 8, 15, 3, 0, 11, 1, 2, 12, 5, 10, 14, 7,
        1, 10, 13, 0, 6, 9, 8, 7, 4, 15, 14, 3, 11, 5, 2, 12},
      '{7, 13, 14, 3, 0, 6, 9, 10, 1, 2, 8, 5, 11, 12, 4, 15,
        13, 8, 11, 5, 6, 15, 0, 3, 4, 7, 2, 12, 1, 10, 14, 9,
        10, 6, 9, 0, 12, 11, 7, 13, 15, 1, 3, 14, 5, 2, 8, 4,
        3, 15, 0, 6, 10, 1, 13, 8, 9, 4, 5, 11, 12, 7, 2, 14},
      '{2, 12, 4, 1, 7, 10, 11, 6, 8, 5, 3, 15, 13, 0, 14, 9,
        14, 11, 2, 12, 4, 7, 13, 1, 5, 0, 15, 10, 3, 9, 8, 6,
        4, 2, 1, 11, 10, 13, 7, 8, 15, 9, 12, 5, 6, 3, 0, 14,
        11, 8, 12, 7, 1, 14, 2, 13, 6, 15, 0, 9, 10, 4, 5, 3},
      '{12, 1, 10, 15, 9, 2, 6, 8, 0, 13, 3, 4, 14, 7, 5, 11,
        10, 15, 4, 2, 7, 12, 9, 5, 6, 1, 13, 14, 0, 11, 3, 8,
        9, 14, 15, 5, 2, 8, 12, 3, 7, 0, 4, 10, 1, 13, 11, 6,
        4, 3, 2, 12, 9, 5, 15, 10, 11, 14, 1, 7, 6, 0, 8, 13},
      '{4, 11, 2, 14, 15, 0, 8, 13, 3, 12, 9, 7, 5, 10, 6, 1,
        13, 0, 11, 7, 4, 9, 1, 10, 14, 3, 5, 12, 2, 15, 8, 6,
        1, 4, 11, 13, 12, 3, 7, 14, 10, 15, 6, 8, 0, 5, 9, 2,
        6, 11, 13, 8, 1, 4, 10, 7, 9, 5, 0, 15, 14, 2, 3, 12},
      '{13, 2, 8, 4, 6, 15, 11, 1, 10, 9, 3, 14, 5, 0, 12, 7,
        1, 15, 13, 8, 10, 3, 7, 4, 12, 5, 6, 11, 0, 14, 9, 2,
        7, 11, 4, 1, 9, 12, 14, 2, 0, 6, 10, 13, 15, 3, 5, 8,
        2, 1, 14, 7, 4, 10, 8, 13, 15, 12, 9, 0, 3, 5, 6, 11}};

endpackage

// ==== round/desSbox.sv ====
module desSbox #(
   parameter int boxIdx = 0
) (
   input logic [5:0] sIn,
   output logic [3:0] sOut
);

   import desTablesPkg::*;

   logic [1:0] row;
   logic [3:0] col;

   // the box number picks one of the eight tables at elaboration time
   if (boxIdx < 0 || boxIdx > 7)
   begin : gBadIdx
      $error("desSbox: boxIdx %0d out of range", boxIdx);
   end

   assign row = {sIn[5], sIn[0]}; // outer bits
   assign col = sIn[4:1]; // middle bits

   always_comb
   begin
      sOut = sboxTable[boxIdx][{row, col}];
   end

endmodule

// ==== round/desRoundFunction.sv ====
module desRoundFunction (
   input logic [desCtrlPkg::HalfW-1:0] rightHalf,
   input logic [desCtrlPkg::SubkeyW-1:0] subkey,
   output logic [desCtrlPkg::HalfW-1:0] fOut
);

   import desCtrlPkg::*;
   import desTablesPkg::*;

   localparam int NumBoxes = 8;

   logic [SubkeyW-1:0] expanded;
   logic [SubkeyW-1:0] mixed;
   logic [HalfW-1:0] sCat;

   // E expansion with DES bit 1 at the msb
   always_comb
   begin
      for (int i = 0; i < SubkeyW; i++)
      begin
         expanded[SubkeyW-1-i] = rightHalf[HalfW - eTable[i]];
      end
   end

   assign mixed = expanded ^ subkey; // subkey mix

   // S1 takes the top six bits and S8 the bottom six
   for (genvar k = 0; k < NumBoxes; k++)
   begin : gBox
      desSbox #(
         .boxIdx(k)
      ) uSbox (
         .sIn(mixed[SubkeyW-1-6*k -: 6]),
         .sOut(sCat[HalfW-1-4*k -: 4])
      );
   end

   // P permutation of the concatenated box outputs
   always_comb
   begin
      for (int i = 0; i < HalfW; i++)
      begin
         fOut[HalfW-1-i] = sCat[HalfW - pTable[i]];
      end
   end

endmodule

// ==== key/desKeySchedule.sv ====
module desKeySchedule (
   input logic clk,
   input logic rstN,
   input logic load,
   input logic step,
   input logic decrypt,
   input logic [desCtrlPkg::RoundIdxW-1:0] roundIdx,
   input logic [desCtrlPkg::KeyW-1:0] key,
   output logic [desCtrlPkg::SubkeyW-1:0] subkey
);

   import desCtrlPkg::*;
   import desTablesPkg::*;

   logic [CdW-1:0] pc1Out;
   logic [CdW-1:0] cdCur;
   logic [HalfCdW-1:0] cReg, dReg;
   logic [HalfCdW-1:0] cCur, dCur;
   logic [RoundIdxW-1:0] decIdx;
   logic decryptQ;
   int encShift;
   int decShift;

   function automatic logic [HalfCdW-1:0] rotL(input logic [HalfCdW-1:0] x, input int n);
      return (x << n) | (x >> (HalfCdW - n));
   endfunction

   function automatic logic [HalfCdW-1:0] rotR(input logic [HalfCdW-1:0] x, input int n);
      return (x >> n) | (x << (HalfCdW - n));
   endfunction

   always_comb
   begin
      for (int i = 0; i < CdW; i++)
      begin
         pc1Out[CdW-1-i] = key[KeyW - pc1Table[i]];
      end
   end

   // C16 equals C0, so decrypt round 0 needs no rotation
   assign decIdx = '0 - roundIdx; // 16 - roundIdx, mod 16
   assign encShift = shiftTable[roundIdx];
   assign decShift = (roundIdx == '0) ? 0 : shiftTable[decIdx];

   assign cCur = decryptQ ? rotR(cReg, decShift) : rotL(cReg, encShift);
   assign dCur = decryptQ ? rotR(dReg, decShift) : rotL(dReg, encShift);
   assign cdCur = {cCur, dCur};

   always_comb
   begin
      for (int i = 0; i < SubkeyW; i++)
      begin
         subkey[SubkeyW-1-i] = cdCur[CdW - pc2Table[i]];
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rstN)
         decryptQ <= 1'b0;
      else if (load)
         decryptQ <= decrypt; // mode held for the whole block
   end

   always_ff @(posedge clk)
   begin
      if (load)
      begin
         cReg <= pc1Out[CdW-1:HalfCdW];
         dReg <= pc1Out[HalfCdW-1:0];
      end
      else if (step)
      begin
         cReg <= cCur; // keep the rotation used this round
         dReg <= dCur;
      end
   end

endmodule

// ==== logic/desDataPath.sv ====
module desDataPath (
   input logic clk,
   input logic rstN,
   input logic load,
   input logic step,
   input logic finish,
   input logic [desCtrlPkg::BlockW-1:0] block,
   input logic [desCtrlPkg::HalfW-1:0] fOut,
   output logic [desCtrlPkg::HalfW-1:0] rightHalf,
   output logic [desCtrlPkg::BlockW-1:0] result
);

   import desCtrlPkg::*;
   import desTablesPkg::*;

   logic [BlockW-1:0] ipOut;
   logic [BlockW-1:0] fpIn;
   logic [BlockW-1:0] fpOut;
   logic [HalfW-1:0] lReg, rReg;

   // initial permutation of the incoming block
   always_comb
   begin
      for (int i = 0; i < BlockW; i++)
      begin
         ipOut[BlockW-1-i] = block[BlockW - ipTable[i]];
      end
   end

   assign fpIn = {rReg, lReg}; // halves swapped after round 16

   always_comb
   begin
      for (int i = 0; i < BlockW; i++)
      begin
         fpOut[BlockW-1-i] = fpIn[BlockW - fpTable[i]];
      end
   end

   always_ff @(posedge clk)
   begin
      if (load)
      begin
         lReg <= ipOut[BlockW-1:HalfW];
         rReg <= ipOut[HalfW-1:0];
      end
      else if (step)
      begin
         lReg <= rReg;
         rReg <= lReg ^ fOut; // Feistel update
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rstN)
         result <= '0;
      else if (finish)
         result <= fpOut; // held until the next finish
   end

   assign rightHalf = rReg;

endmodule

// ==== logic/desControl.sv ====
module desControl (
   input logic clk,
   input logic rstN,
   input logic req,
   output logic ack,
   output logic load,
   output logic step,
   output logic finish,
   output logic [desCtrlPkg::RoundIdxW-1:0] roundIdx
);

   import desCtrlPkg::*;

   ctrlState state;
   logic ackQ;
   logic [RoundIdxW-1:0] roundCnt;

   // ack rises 19 edges after req is first sampled high
   always_ff @(posedge clk)
   begin
      if (!rstN)
      begin
         state <= Idle;
         ackQ <= 1'b0;
         roundCnt <= '0;
      end
      else
      begin
         case (state)
            Idle:
            begin
               if (req)
                  state <= Load;
            end
            Load:
            begin
               roundCnt <= '0;
               state <= Round;
            end
            Round:
            begin
               roundCnt <= roundCnt + 1'b1; // wraps to zero after round 15
               if (roundCnt == RoundIdxW'(NumRounds - 1))
                  state <= Finish;
            end
            Finish:
               state <= Done;
            Done:
            begin
               if (!ackQ)
                  ackQ <= 1'b1;
               else if (!req)
               begin
                  ackQ <= 1'b0; // fourth phase of the handshake
                  state <= Idle;
               end
            end
            default:
               state <= Idle;
         endcase
      end
   end

   // strobes decoded straight from the state
   assign load = (state == Load);
   assign step = (state == Round);
   assign finish = (state == Finish);
   assign roundIdx = roundCnt;
   assign ack = ackQ;

endmodule

// ==== logic/desCore.sv ====
module desCore (
   input logic clk,
   input logic rstN,
   input logic req,
   output logic ack,
   input logic decrypt,
   input logic [desCtrlPkg::BlockW-1:0] block,
   input logic [desCtrlPkg::KeyW-1:0] key,
   output logic [desCtrlPkg::BlockW-1:0] result
);

   import desCtrlPkg::*;

   logic load;
   logic step;
   logic finish;
   logic [RoundIdxW-1:0] roundIdx;
   logic [SubkeyW-1:0] subkey;
   logic [HalfW-1:0] rightHalf;
   logic [HalfW-1:0] fOut;

   desControl uControl (
      .clk(clk),
      .rstN(rstN),
      .req(req),
      .ack(ack),
      .load(load),
      .step(step),
      .finish(finish),
      .roundIdx(roundIdx)
   );

   desKeySchedule uKeySchedule (
      .clk(clk),
      .rstN(rstN),
      .load(load),
      .step(step),
      .decrypt(decrypt),
      .roundIdx(roundIdx),
      .key(key),
      .subkey(subkey)
   );

   desRoundFunction uRoundFunction (
      .rightHalf(rightHalf),
      .subkey(subkey),
      .fOut(fOut)
   );

   desDataPath uDataPath (
      .clk(clk),
      .rstN(rstN),
      .load(load),
      .step(step),
      .finish(finish),
      .block(block),
      .fOut(fOut),
      .rightHalf(rightHalf),
      .result(result)
   );

endmodule

// ==== verif/desCore_sva.sv ====
module desCoreSva (
   input logic clk,
   input logic rstN,
   input logic req,
   input logic ack,
   input logic decrypt,
   input logic [desCtrlPkg::BlockW-1:0] block,
   input logic [desCtrlPkg::KeyW-1:0] key
);

   timeunit 1ns;
   timeprecision 1ps;

   ackLowInReset: assert property (@(posedge clk) !rstN |=> !ack)
      else $error("ack high after a reset edge");

   // ack changes on the 19th edge after req is sampled, so it is seen one tick later
   ackLatency: assert property (@(posedge clk) disable iff (!rstN)
      $rose(req) |-> ##20 $rose(ack))
      else $error("ack did not rise 19 edges after req");

   reqHeld: assert property (@(posedge clk) disable iff (!rstN)
      req && !ack |=> req)
      else $error("req dropped before ack");

   inputsStable: assert property (@(posedge clk) disable iff (!rstN)
      req |=> !req || ($stable(block) && $stable(key) && $stable(decrypt)))
      else $error("block, key or decrypt changed while req was high");

endmodule

bind desCore desCoreSva uSva (
   .clk(clk),
   .rstN(rstN),
   .req(req),
   .ack(ack),
   .decrypt(decrypt),
   .block(block),
   .key(key)
);

// ==== verif/desCoreTb.sv ====
module desCoreTb;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int AckTimeout = 100; // cycles, well above the 19-edge latency
   localparam logic [63:0] KatKey = 64'h133457799BBCDFF1;
   localparam logic [63:0] KatPlain = 64'h0123456789ABCDEF;
   localparam logic [63:0] KatCipher = 64'h85E813540F0AB405;

   // reference copy of the standard tables, 1-based bit numbers from the msb
   localparam int ipTbl [64] = '{
      58, 50, 42, 34, 26, 18, 10, 2, 60, 52, 44, 36, 28, 20, 12, 4,
      62, 54, 46, 38, 30, 22, 14, 6, 64, 56, 48, 40, 32, 24, 16, 8,
      57, 49, 41, 33, 25, 17, 9, 1, 59, 51, 43, 35, 27, 19, 11, 3,
      61, 53, 45, 37, 29, 21, 13, 5, 63, 55, 47, 39, 31, 23, 15, 7};
   localparam int eTbl [48] = '{32, 1, 2, 3, 4, 5, 4, 5, 6, 7, 8, 9, 8, 9, 10, 11,
      12, 13, 12, 13, 14, 15, 16, 17, 16, 17, 18, 19, 20, 21, 20, 21,
      22, 23, 24, 25, 24, 25, 26, 27, 28, 29, 28, 29, 30, 31, 32, 1};
   localparam int pTbl [32] = '{16, 7, 20, 21, 29, 12, 28, 17, 1, 15, 23, 26, 5, 18, 31, 10,
      2, 8, 24, 14, 32, 27, 3, 9, 19, 13, 30, 6, 22, 11, 4, 25};
   localparam int pc1Tbl [56] = '{57, 49, 41, 33, 25, 17, 9, 1, 58, 50, 42, 34, 26, 18,
      10, 2, 59, 51, 43, 35, 27, 19, 11, 3, 60, 52, 44, 36,
      63, 55, 47, 39, 31, 23, 15, 7, 62, 54, 46, 38, 30, 22,
      14, 6, 61, 53, 45, 37, 29, 21, 13, 5, 28, 20, 12, 4};
   localparam int pc2Tbl [48] = '{14, 17, 11, 24, 1, 5, 3, 28, 15, 6, 21, 10, 23, 19, 12, 4,
      26, 8, 16, 7, 27, 20, 13, 2, 41, 52, 31, 37, 47, 55, 30, 40,
      51, 45, 33, 48, 44, 49, 39, 56, 34, 53, 46, 42, 50, 36, 29, 32};
   localparam int shiftTbl [16] = '{1, 1, 2, 2, 2, 2, 2, 2, 1, 2, 2, 2, 2, 2, 2, 1};
   // one row of 16 nibbles per underscore group, entry 0 in the top nibble
   localparam logic [255:0] sboxTbl [8] = '{
      256'hE4D12FB83A6C5907_0F74E2D1A6CB9538_41E8D62BFC973A50_FC8249175B3EA06D,
      256'hF18E6B34972DC05A_3D47F28EC01A69B5_0E7BA4D158C6932F_D8A13F42B67C05E9,
      256'hA09E63F51DC7B428_D709346A285ECBF1_D6498F30B12C5AE7_1AD069874FE3B52C,
      256'h7DE3069A1285BC4F_D8B56F03472C1AE9_A690CB7DF13E5284_3F06A1D8945BC72E,
      256'h2C417AB6853FD0E9_EB2C47D150FA3986_421BAD78F9C5630E_B8C71E2D6F09A453,
      256'hC1AF92680D34E75B_AF427C9561DE0B38_9EF528C3704A1DB6_432C95FABE17608D,
      256'h4B2EF08D3C975A61_D0B7491AE35C2F86_14BDC37EAF680592_6BD814A7950FE23C,
      256'hD2846FB1A93E50C7_1FD8A374C56B0E92_7B419CE206ADF358_21E74A8DFC90356B};

   logic clk, rstN, req, ack, decrypt;
   logic [63:0] block, key, result;
   int errCount = 0;
   int checkCount = 0;
   int lastErrCount = 0; // error count when the previous test ended

   desCore UUT (.*);

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk; // 20 ns period
   end

   task automatic checkValue(input string name, input logic [63:0] got,
      input logic [63:0] expected);
      checkCount++;
      if (got !== expected)
      begin
         errCount++;
         $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, expected);
      end
   endtask

   task automatic testDone(input string name);
      $display("%s: %0d errors", name, errCount - lastErrCount);
      lastErrCount = errCount;
   endtask

   // count rising edges until ack reaches level, looking at it on the falling edge
   task automatic waitAck(input logic level, output int edges);
      edges = 0;
      do
      begin
         @(posedge clk);
         edges++;
         @(negedge clk);
      end
      while (ack !== level && edges < AckTimeout);
      if (ack !== level)
      begin
         errCount++;
         $display("timeout: ack did not go %s within %0d cycles", level ? "high" : "low",
            AckTimeout);
      end
   endtask

   // one four-phase handshake, req held for hold extra cycles once ack is seen
   task automatic transact(input logic [63:0] k, input logic [63:0] blk, input logic dec,
      input int hold, output logic [63:0] res, output int riseEdges, output int fallEdges);
      @(posedge clk);
      key <= k;
      block <= blk;
      decrypt <= dec;
      req <= 1'b1;
      waitAck(1'b1, riseEdges);
      riseEdges--; // first counted edge is the one that samples req
      res = result;
      repeat (hold)
      begin
         @(negedge clk);
         checkValue("ack", 64'(ack), 64'd1);
         checkValue("result", result, res);
      end
      @(posedge clk);
      req <= 1'b0;
      waitAck(1'b0, fallEdges);
   endtask

   task automatic runAndCheck(input string name, input logic [63:0] k, input logic [63:0] blk,
      input logic dec, input logic [63:0] expected);
      logic [63:0] res;
      int rise, fall;
      transact(k, blk, dec, 0, res, rise, fall);
      checkValue(name, res, expected);
   endtask

   // behavioral DES, final permutation done as the inverse of IP
   function automatic logic [63:0] refDes(input logic [63:0] k, input logic [63:0] blk,
      input logic dec);
      logic [55:0] cd;
      logic [47:0] sk [16];
      logic [47:0] e;
      logic [63:0] ip, res;
      logic [31:0] l, r, s, f;
      int idx;
      for (int i = 0; i < 56; i++)
         cd[55-i] = k[64-pc1Tbl[i]];
      for (int n = 0; n < 16; n++)
      begin
         for (int j = 0; j < shiftTbl[n]; j++)
            cd = {cd[54:28], cd[55], cd[26:0], cd[27]}; // C and D rotate left
         for (int i = 0; i < 48; i++)
            sk[n][47-i] = cd[56-pc2Tbl[i]];
      end
      for (int i = 0; i < 64; i++)
         ip[63-i] = blk[64-ipTbl[i]];
      l = ip[63:32];
      r = ip[31:0];
      for (int n = 0; n < 16; n++)
      begin
         for (int i = 0; i < 48; i++)
            e[47-i] = r[32-eTbl[i]];
         e = e ^ sk[dec ? 15 - n : n]; // subkeys reversed for decrypt
         for (int b = 0; b < 8; b++)
         begin
            idx = int'({e[47-6*b], e[42-6*b], e[46-6*b -: 4]}); // row then column
            s[31-4*b -: 4] = sboxTbl[b][255-4*idx -: 4];
         end
         for (int i = 0; i < 32; i++)
            f[31-i] = s[32-pTbl[i]];
         {l, r} = {r, l ^ f};
      end
      ip = {r, l};
      for (int i = 0; i < 64; i++)
         res[64-ipTbl[i]] = ip[63-i];
      return res;
   endfunction

   task automatic testResetState();
      @(negedge clk);
      checkValue("ack", 64'(ack), 64'd0);
      checkValue("result", result, 64'd0);
      testDone("reset state");
   endtask

   task automatic testKnownEncrypt();
      runAndCheck("result", KatKey, KatPlain, 1'b0, KatCipher);
      runAndCheck("result", 64'd0, 64'd0, 1'b0, 64'h8CA64DE9C1B123A7);
      testDone("known answer encrypt");
   endtask

   task automatic testKnownDecrypt();
      runAndCheck("result", KatKey, KatCipher, 1'b1, KatPlain);
      runAndCheck("result", 64'd0, 64'h8CA64DE9C1B123A7, 1'b1, 64'd0);
      testDone("known answer decrypt");
   endtask

   task automatic testRoundTrip();
      logic [63:0] k, b, ct;
      int rise, fall;
      for (int n = 0; n < 20; n++)
      begin
         k = {$urandom, $urandom};
         b = {$urandom, $urandom};
         transact(k, b, 1'b0, 0, ct, rise, fall);
         checkValue("ciphertext", ct, refDes(k, b, 1'b0));
         runAndCheck("plaintext", k, ct, 1'b1, b);
      end
      testDone("round trip");
   endtask

   task automatic testHandshake();
      logic [63:0] res;
      int rise, fall;
      transact(KatKey, KatPlain, 1'b0, 4, res, rise, fall);
      checkValue("ackRiseEdges", 64'(rise), 64'd19);
      checkValue("ackFallEdges", 64'(fall), 64'd1);
      checkValue("result", res, KatCipher);
      testDone("handshake timing");
   endtask

   // transact returns right after ack falls, so each req follows at once
   task automatic testBackToBack();
      logic [63:0] k, b;
      for (int n = 0; n < 4; n++)
      begin
         k = {$urandom, $urandom};
         b = {$urandom, $urandom};
         runAndCheck("result", k, b, n[0], refDes(k, b, n[0]));
      end
      testDone("back to back");
   endtask

   initial
   begin
      void'($urandom(32'h7cb2));
      rstN = 1'b0;
      req = 1'b0;
      decrypt = 1'b0;
      block = '0;
      key = '0;
      repeat (5) @(posedge clk);
      rstN <= 1'b1;
      testResetState();
      testKnownEncrypt();
      testKnownDecrypt();
      testRoundTrip();
      testHandshake();
      testBackToBack();
      $display("%0d checks, %0d errors", checkCount, errCount);
      if (errCount == 0)
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   end

endmodule

// ==== sim.f ====
common/desCtrlPkg.sv
common/desTablesPkg.sv
round/desSbox.sv
round/desRoundFunction.sv
key/desKeySchedule.sv
logic/desDataPath.sv
logic/desControl.sv
logic/desCore.sv
verif/desCore_sva.sv
verif/desCoreTb.sv

// ==== run.sh ====
#!/bin/sh
# Build the DES core testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module desCoreTb -f sim.f -o desCoreSim

./obj_dir/desCoreSim | tee sim.log

if grep -q "All checks passed" sim.log; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi
